// ==== Bender.yml ====
package:
  name: rv_pipeline

export_include_dirs:
  - include

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/insn_mem.sv
      - logic/reg_file.sv
      - logic/decode_unit.sv
      - logic/alu.sv
      - logic/rv_pipeline.sv
  - target: test
    files:
      - tests/rv_pipeline_tb.sv

// ==== files.f ====
+incdir+include
logic/rv_pkg.sv
logic/insn_mem.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/alu.sv
logic/rv_pipeline.sv
tests/rv_pipeline_tb.sv

// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and pc width
`define RV_XLEN 32

// every rv32 instruction is one word
`define RV_INSN_W 32

// register file geometry
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// program store holds 1 KiB of code
`define RV_IMEM_WORDS 256
`define RV_IMEM_ADDR_W 8

// no compressed instructions so fetch always moves one word
`define RV_PC_STEP 4

`endif

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module alu (
  input  rv_pkg::alu_op_e     alu_op,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  logic [`RV_XLEN-1:0] imm,
  output logic [`RV_XLEN-1:0] result
);

  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;

  // register group uses rs2, everything else the immediate
  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD, rv_pkg::ALU_SUB, rv_pkg::ALU_SLL, rv_pkg::ALU_SLT,
      rv_pkg::ALU_SLTU, rv_pkg::ALU_XOR, rv_pkg::ALU_SRL, rv_pkg::ALU_SRA,
      rv_pkg::ALU_OR, rv_pkg::ALU_AND: begin
        op_b = b;
      end
      default: begin
        op_b = imm;
      end
    endcase
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_LUI:                    result = imm;
      rv_pkg::ALU_ADD, rv_pkg::ALU_ADDI:  result = a + op_b;
      rv_pkg::ALU_SUB:                    result = a - op_b;
      rv_pkg::ALU_SLT, rv_pkg::ALU_SLTI: begin
        result = {31'b0, $signed(a) < $signed(op_b)};
      end
      rv_pkg::ALU_SLTU, rv_pkg::ALU_SLTIU: begin
        // immediate is sign extended first, then compared unsigned
        result = {31'b0, a < op_b};
      end
      rv_pkg::ALU_XOR, rv_pkg::ALU_XORI:  result = a ^ op_b;
      rv_pkg::ALU_OR, rv_pkg::ALU_ORI:    result = a | op_b;
      rv_pkg::ALU_AND, rv_pkg::ALU_ANDI:  result = a & op_b;
      rv_pkg::ALU_SLL, rv_pkg::ALU_SLLI:  result = a << shamt;
      rv_pkg::ALU_SRL, rv_pkg::ALU_SRLI:  result = a >> shamt;
      rv_pkg::ALU_SRA, rv_pkg::ALU_SRAI: begin
        result = $unsigned($signed(a) >>> shamt);
      end
      // bubble
      default:                            result = '0;
    endcase
  end

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module decode_unit (
  input  logic [`RV_INSN_W-1:0]     insn,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_REG_ADDR_W-1:0] rd,
  output logic [`RV_XLEN-1:0]       imm,
  output rv_pkg::alu_op_e           alu_op,
  output logic                      we
);

  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;

  // fixed field positions of the R and I formats
  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // shamt already lands in imm_i[4:0]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};

  assign imm = (opcode == rv_pkg::OPC_LUI) ? imm_u : imm_i;

  always_comb begin
    alu_op = rv_pkg::ALU_NOP;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        alu_op = rv_pkg::ALU_LUI;
      end
      rv_pkg::OPC_OP_IMM: begin
        case (funct3)
          3'b000: alu_op = rv_pkg::ALU_ADDI;
          3'b010: alu_op = rv_pkg::ALU_SLTI;
          3'b011: alu_op = rv_pkg::ALU_SLTIU;
          3'b100: alu_op = rv_pkg::ALU_XORI;
          3'b110: alu_op = rv_pkg::ALU_ORI;
          3'b111: alu_op = rv_pkg::ALU_ANDI;
          3'b001: begin
            if (funct7 == F7_BASE) begin
              alu_op = rv_pkg::ALU_SLLI;
            end
          end
          3'b101: begin
            // funct7 tells logical from arithmetic shift
            if (funct7 == F7_BASE) begin
              alu_op = rv_pkg::ALU_SRLI;
            end else if (funct7 == F7_ALT) begin
              alu_op = rv_pkg::ALU_SRAI;
            end
          end
          default: alu_op = rv_pkg::ALU_NOP;
        endcase
      end
      rv_pkg::OPC_OP: begin
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: alu_op = rv_pkg::ALU_ADD;
          {F7_ALT, 3'b000}:  alu_op = rv_pkg::ALU_SUB;
          {F7_BASE, 3'b001}: alu_op = rv_pkg::ALU_SLL;
          {F7_BASE, 3'b010}: alu_op = rv_pkg::ALU_SLT;
          {F7_BASE, 3'b011}: alu_op = rv_pkg::ALU_SLTU;
          {F7_BASE, 3'b100}: alu_op = rv_pkg::ALU_XOR;
          {F7_BASE, 3'b101}: alu_op = rv_pkg::ALU_SRL;
          {F7_ALT, 3'b101}:  alu_op = rv_pkg::ALU_SRA;
          {F7_BASE, 3'b110}: alu_op = rv_pkg::ALU_OR;
          {F7_BASE, 3'b111}: alu_op = rv_pkg::ALU_AND;
          // mul/div and anything else
          default:           alu_op = rv_pkg::ALU_NOP;
        endcase
      end
      default: begin
        alu_op = rv_pkg::ALU_NOP;
      end
    endcase
  end

  // every supported instruction writes rd
  assign we = (alu_op != rv_pkg::ALU_NOP);

endmodule

// ==== logic/insn_mem.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module insn_mem (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`RV_XLEN-1:0]        pc,
  input  logic                       imem_we,
  input  logic [`RV_IMEM_ADDR_W-1:0] imem_addr,
  input  logic [`RV_INSN_W-1:0]      imem_wdata,
  output logic [`RV_INSN_W-1:0]      insn
);

  logic [`RV_INSN_W-1:0] mem [`RV_IMEM_WORDS];

  // word index taken from the pc above the byte offset
  // upper pc bits are dropped so fetch wraps around the array
  logic [`RV_IMEM_ADDR_W-1:0] fetch_addr;

  assign fetch_addr = pc[`RV_IMEM_ADDR_W+1:2];

  // program load only while the core is held in reset
  always_ff @(posedge clk) begin
    if (rst && imem_we) begin
      mem[imem_addr] <= imem_wdata;
    end
  end

  // fetch is combinational
  assign insn = mem[fetch_addr];

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic [`RV_XLEN-1:0]       rd_data,
  input  logic                      we,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 always reads zero
  // a write in the same cycle is bypassed to the reader
  assign rs1_data = (rs1 == '0) ? '0 :
                    (we && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (we && rd == rs2) ? rd_data : regs[rs2];

endmodule

// ==== logic/rv_pipeline.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_pipeline (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       imem_we,
  input  logic [`RV_IMEM_ADDR_W-1:0] imem_addr,
  input  logic [`RV_INSN_W-1:0]      imem_wdata,
  output logic [`RV_XLEN-1:0]        trace_pc,
  output logic [`RV_INSN_W-1:0]      trace_insn,
  output rv_pkg::cycle_status_e      trace_status,
  output logic                       trace_we,
  output logic [`RV_REG_ADDR_W-1:0]  trace_rd,
  output logic [`RV_XLEN-1:0]        trace_rd_data
);

  // fetch
  logic [`RV_XLEN-1:0]   f_pc;
  logic [`RV_INSN_W-1:0] f_insn;

  // decode
  logic [`RV_XLEN-1:0]        d_pc;
  logic [`RV_INSN_W-1:0]      d_insn;
  rv_pkg::cycle_status_e      d_status;
  logic [`RV_REG_ADDR_W-1:0]  dec_rs1;
  logic [`RV_REG_ADDR_W-1:0]  dec_rs2;
  logic [`RV_REG_ADDR_W-1:0]  dec_rd;
  logic [`RV_XLEN-1:0]        dec_imm;
  rv_pkg::alu_op_e            dec_alu_op;
  logic                       dec_we;

  // execute
  logic [`RV_XLEN-1:0]        x_pc;
  logic [`RV_INSN_W-1:0]      x_insn;
  rv_pkg::cycle_status_e      x_status;
  logic [`RV_REG_ADDR_W-1:0]  x_rs1;
  logic [`RV_REG_ADDR_W-1:0]  x_rs2;
  logic [`RV_REG_ADDR_W-1:0]  x_rd;
  logic [`RV_XLEN-1:0]        x_imm;
  rv_pkg::alu_op_e            x_alu_op;
  logic                       x_we;
  logic [`RV_XLEN-1:0]        x_rs1_data;
  logic [`RV_XLEN-1:0]        x_rs2_data;
  logic [`RV_XLEN-1:0]        x_result;

  // memory
  logic [`RV_XLEN-1:0]        m_pc;
  logic [`RV_INSN_W-1:0]      m_insn;
  rv_pkg::cycle_status_e      m_status;
  logic [`RV_REG_ADDR_W-1:0]  m_rd;
  logic [`RV_XLEN-1:0]        m_result;
  logic                       m_we;

  // writeback
  logic [`RV_XLEN-1:0]        w_pc;
  logic [`RV_INSN_W-1:0]      w_insn;
  rv_pkg::cycle_status_e      w_status;
  logic [`RV_REG_ADDR_W-1:0]  w_rd;
  logic [`RV_XLEN-1:0]        w_result;
  logic                       w_we;

  // straight-line fetch, nothing ever redirects the pc
  always_ff @(posedge clk) begin
    if (rst) begin
      f_pc <= '0;
    end else begin
      f_pc <= f_pc + `RV_PC_STEP;
    end
  end

  insn_mem insn_mem_inst (
    .clk        (clk),
    .rst        (rst),
    .pc         (f_pc),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .insn       (f_insn)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pkg::CYCLE_RESET;
    end else begin
      d_pc     <= f_pc;
      d_insn   <= f_insn;
      d_status <= rv_pkg::CYCLE_NO_STALL;
    end
  end

  decode_unit decode_unit_inst (
    .insn   (d_insn),
    .rs1    (dec_rs1),
    .rs2    (dec_rs2),
    .rd     (dec_rd),
    .imm    (dec_imm),
    .alu_op (dec_alu_op),
    .we     (dec_we)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rv_pkg::CYCLE_RESET;
      x_alu_op <= rv_pkg::ALU_NOP;
      x_we     <= 1'b0;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_status <= d_status;
      x_alu_op <= dec_alu_op;
      x_we     <= dec_we;
    end
  end

  always_ff @(posedge clk) begin
    x_rs1 <= dec_rs1;
    x_rs2 <= dec_rs2;
    x_rd  <= dec_rd;
    x_imm <= dec_imm;
  end

  // read in execute, written from writeback with bypass
  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (x_rs1),
    .rs2      (x_rs2),
    .rd       (w_rd),
    .rd_data  (w_result),
    .we       (w_we),
    .rs1_data (x_rs1_data),
    .rs2_data (x_rs2_data)
  );

  alu alu_inst (
    .alu_op (x_alu_op),
    .a      (x_rs1_data),
    .b      (x_rs2_data),
    .imm    (x_imm),
    .result (x_result)
  );

  // memory stage only delays the result by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_status <= rv_pkg::CYCLE_RESET;
      m_we     <= 1'b0;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
      m_we     <= x_we;
    end
  end

  always_ff @(posedge clk) begin
    m_rd     <= x_rd;
    m_result <= x_result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc     <= '0;
      w_insn   <= '0;
      w_status <= rv_pkg::CYCLE_RESET;
      w_we     <= 1'b0;
    end else begin
      w_pc     <= m_pc;
      w_insn   <= m_insn;
      w_status <= m_status;
      w_we     <= m_we;
    end
  end

  always_ff @(posedge clk) begin
    w_rd     <= m_rd;
    w_result <= m_result;
  end

  // trace shows whatever sits in writeback this cycle
  assign trace_pc      = w_pc;
  assign trace_insn    = w_insn;
  assign trace_status  = w_status;
  assign trace_we      = w_we;
  assign trace_rd      = w_rd;
  assign trace_rd_data = w_result;

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  // major opcodes of the base integer isa
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b00_000_11,
    OPC_MISC_MEM = 7'b00_011_11,
    OPC_OP_IMM   = 7'b00_100_11,
    OPC_AUIPC    = 7'b00_101_11,
    OPC_STORE    = 7'b01_000_11,
    OPC_OP       = 7'b01_100_11,
    OPC_LUI      = 7'b01_101_11,
    OPC_BRANCH   = 7'b11_000_11,
    OPC_JALR     = 7'b11_001_11,
    OPC_JAL      = 7'b11_011_11,
    OPC_SYSTEM   = 7'b11_100_11
  } opcode_e;

  // one operation per supported instruction
  // ALU_NOP marks a bubble that writes nothing
  typedef enum logic [4:0] {
    ALU_NOP,
    ALU_LUI,
    // register-immediate group
    ALU_ADDI,
    ALU_SLTI,
    ALU_SLTIU,
    ALU_XORI,
    ALU_ORI,
    ALU_ANDI,
    ALU_SLLI,
    ALU_SRLI,
    ALU_SRAI,
    // register-register group
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // classifies the cycle that each stage holds
  // travels down the pipe alongside the instruction
  typedef enum logic [1:0] {
    // never seen once reset has drained
    CYCLE_INVALID  = 2'd0,
    // bubble left behind by reset
    CYCLE_RESET    = 2'd1,
    // a real instruction
    CYCLE_NO_STALL = 2'd2
  } cycle_status_e;

endpackage

// ==== tests/rv_pipeline_tb.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_pipeline_tb;

  // base isa field values, taken from the instruction set manual
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;
  localparam int RESET_CYCLES = 8;
  localparam int FILL_CYCLES  = 4;

  logic                       clk;
  logic                       rst;
  logic                       imem_we;
  logic [`RV_IMEM_ADDR_W-1:0] imem_addr;
  logic [`RV_INSN_W-1:0]      imem_wdata;
  logic [`RV_XLEN-1:0]        trace_pc;
  logic [`RV_INSN_W-1:0]      trace_insn;
  rv_pkg::cycle_status_e      trace_status;
  logic                       trace_we;
  logic [`RV_REG_ADDR_W-1:0]  trace_rd;
  logic [`RV_XLEN-1:0]        trace_rd_data;

  // stimulus table, one row per instruction, all tests back to back
  logic [31:0] tab_insn [$];
  logic        tab_we [$];
  logic [4:0]  tab_rd [$];
  logic [31:0] tab_data [$];
  string       test_name [$];
  int          test_first [$];
  int          test_len [$];

  logic [31:0] rand_state = 32'd17186;
  int cycle_cnt = 0;
  int cycle_limit = 0;
  bit limit_ready = 1'b0;
  int check_cnt = 0;
  int mismatch_cnt = 0;
  int failed_tests = 0;

  rv_pipeline rv_pipeline_inst (
    .clk           (clk),
    .rst           (rst),
    .imem_we       (imem_we),
    .imem_addr     (imem_addr),
    .imem_wdata    (imem_wdata),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_we      (trace_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit_ready && cycle_cnt >= cycle_limit) begin
      $display("the run timed out after %0d cycles", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic void add_row(input logic [31:0] insn, input logic we,
                                  input logic [4:0] rd, input logic [31:0] data);
    tab_insn.push_back(insn);
    tab_we.push_back(we);
    tab_rd.push_back(rd);
    tab_data.push_back(data);
  endfunction

  function automatic void start_test(input string name);
    test_name.push_back(name);
    test_first.push_back(tab_insn.size());
  endfunction

  function automatic void close_test();
    test_len.push_back(tab_insn.size() - test_first[test_first.size() - 1]);
  endfunction

  // addi/xori chain checked against a register model
  // rs1 never names the rd of the row just before
  function automatic void add_random_chain(input int n);
    logic [31:0] model [32];
    logic [31:0] r;
    logic [31:0] val;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  prev_rd;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    prev_rd = '0;
    for (int k = 0; k < n; k++) begin
      r = next_rand();
      rd = 5'd1 + 5'(r % 31);
      rs1 = r[12:8];
      if (rs1 == prev_rd) begin
        rs1 = 5'd0;
      end
      imm = r[31:20];
      if (r[16]) begin
        val = model[rs1] ^ sext12(imm);
        add_row(imm_op(F3_XOR, rd, rs1, imm), 1'b1, rd, val);
      end else begin
        val = model[rs1] + sext12(imm);
        add_row(imm_op(F3_ADD, rd, rs1, imm), 1'b1, rd, val);
      end
      model[rd] = val;
      prev_rd = rd;
    end
  endfunction

  function automatic void build_tables();
    start_test("reset_fill");
    add_row(imm_op(F3_ADD, 5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'h0000_0005);
    add_row(imm_op(F3_ADD, 5'd2, 5'd0, 12'd7), 1'b1, 5'd2, 32'h0000_0007);
    add_row(imm_op(F3_ADD, 5'd3, 5'd1, 12'd1), 1'b1, 5'd3, 32'h0000_0006);
    close_test();

    start_test("imm_group");
    add_row(lui_word(5'd1, 20'h80000), 1'b1, 5'd1, 32'h8000_0000);
    add_row(imm_op(F3_ADD, 5'd2, 5'd0, 12'hFFB), 1'b1, 5'd2, 32'hFFFF_FFFB);
    add_row(imm_op(F3_ADD, 5'd3, 5'd0, 12'h003), 1'b1, 5'd3, 32'h0000_0003);
    add_row(imm_op(F3_ADD, 5'd4, 5'd1, 12'hFFF), 1'b1, 5'd4, 32'h7FFF_FFFF);
    add_row(imm_op(F3_SLT, 5'd5, 5'd2, 12'h003), 1'b1, 5'd5, 32'h0000_0001);
    add_row(imm_op(F3_SLTU, 5'd6, 5'd2, 12'h003), 1'b1, 5'd6, 32'h0000_0000);
    add_row(imm_op(F3_XOR, 5'd7, 5'd2, 12'h0F0), 1'b1, 5'd7, 32'hFFFF_FF0B);
    add_row(imm_op(F3_OR, 5'd8, 5'd3, 12'hF00), 1'b1, 5'd8, 32'hFFFF_FF03);
    add_row(imm_op(F3_AND, 5'd9, 5'd2, 12'h07F), 1'b1, 5'd9, 32'h0000_007B);
    add_row(imm_op(F3_SLL, 5'd10, 5'd8, 12'h004), 1'b1, 5'd10, 32'hFFFF_F030);
    add_row(imm_op(F3_SR, 5'd11, 5'd1, 12'h004), 1'b1, 5'd11, 32'h0800_0000);
    add_row(imm_op(F3_SR, 5'd12, 5'd1, 12'h404), 1'b1, 5'd12, 32'hF800_0000);
    close_test();

    start_test("reg_group");
    add_row(imm_op(F3_ADD, 5'd1, 5'd0, 12'hFF9), 1'b1, 5'd1, 32'hFFFF_FFF9);
    add_row(imm_op(F3_ADD, 5'd2, 5'd0, 12'h005), 1'b1, 5'd2, 32'h0000_0005);
    add_row(lui_word(5'd5, 20'h80000), 1'b1, 5'd5, 32'h8000_0000);
    add_row(reg_op(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'hFFFF_FFFE);
    add_row(reg_op(F7_ALT, F3_ADD, 5'd4, 5'd2, 5'd1), 1'b1, 5'd4, 32'h0000_000C);
    add_row(reg_op(F7_ALT, F3_ADD, 5'd6, 5'd5, 5'd2), 1'b1, 5'd6, 32'h7FFF_FFFB);
    add_row(reg_op(F7_BASE, F3_SLT, 5'd7, 5'd1, 5'd2), 1'b1, 5'd7, 32'h0000_0001);
    add_row(reg_op(F7_BASE, F3_SLTU, 5'd8, 5'd1, 5'd2), 1'b1, 5'd8, 32'h0000_0000);
    add_row(reg_op(F7_BASE, F3_XOR, 5'd9, 5'd1, 5'd2), 1'b1, 5'd9, 32'hFFFF_FFFC);
    add_row(reg_op(F7_BASE, F3_OR, 5'd10, 5'd1, 5'd2), 1'b1, 5'd10, 32'hFFFF_FFFD);
    add_row(reg_op(F7_BASE, F3_AND, 5'd11, 5'd1, 5'd2), 1'b1, 5'd11, 32'h0000_0001);
    add_row(reg_op(F7_BASE, F3_SLL, 5'd12, 5'd2, 5'd2), 1'b1, 5'd12, 32'h0000_00A0);
    add_row(reg_op(F7_BASE, F3_SR, 5'd13, 5'd1, 5'd2), 1'b1, 5'd13, 32'h07FF_FFFF);
    add_row(reg_op(F7_ALT, F3_SR, 5'd14, 5'd1, 5'd2), 1'b1, 5'd14, 32'hFFFF_FFFF);
    add_row(reg_op(F7_ALT, F3_ADD, 5'd15, 5'd0, 5'd2), 1'b1, 5'd15, 32'hFFFF_FFFB);
    close_test();

    // consumers sit exactly two rows after their producers
    start_test("write_through");
    add_row(imm_op(F3_ADD, 5'd1, 5'd0, 12'd100), 1'b1, 5'd1, 32'h0000_0064);
    add_row(imm_op(F3_ADD, 5'd2, 5'd0, 12'd1), 1'b1, 5'd2, 32'h0000_0001);
    add_row(imm_op(F3_ADD, 5'd3, 5'd1, 12'd23), 1'b1, 5'd3, 32'h0000_007B);
    add_row(imm_op(F3_XOR, 5'd4, 5'd0, 12'h055), 1'b1, 5'd4, 32'h0000_0055);
    add_row(reg_op(F7_BASE, F3_ADD, 5'd5, 5'd3, 5'd1), 1'b1, 5'd5, 32'h0000_00DF);
    add_row(imm_op(F3_ADD, 5'd6, 5'd2, 12'd2), 1'b1, 5'd6, 32'h0000_0003);
    add_row(reg_op(F7_ALT, F3_ADD, 5'd7, 5'd5, 5'd3), 1'b1, 5'd7, 32'h0000_0064);
    close_test();

    // sw x1,0(x0), beq x0,x0,+8 and slli with a bad funct7 are bubbles
    start_test("x0_unsupported");
    add_row(imm_op(F3_ADD, 5'd0, 5'd0, 12'd123), 1'b1, 5'd0, 32'h0000_007B);
    add_row(imm_op(F3_ADD, 5'd1, 5'd0, 12'd9), 1'b1, 5'd1, 32'h0000_0009);
    add_row(imm_op(F3_ADD, 5'd2, 5'd0, 12'd1), 1'b1, 5'd2, 32'h0000_0001);
    add_row(32'h0010_2023, 1'b0, 5'd0, 32'h0);
    add_row(32'h0000_0463, 1'b0, 5'd0, 32'h0);
    add_row(reg_op(F7_BASE, F3_ADD, 5'd3, 5'd0, 5'd1), 1'b1, 5'd3, 32'h0000_0009);
    add_row(imm_op(F3_SLL, 5'd5, 5'd1, 12'h401), 1'b0, 5'd0, 32'h0);
    add_row(reg_op(F7_BASE, F3_OR, 5'd4, 5'd2, 5'd0), 1'b1, 5'd4, 32'h0000_0001);
    close_test();

    start_test("random_chain");
    add_random_chain(20);
    close_test();
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic run_test(input int t);
    int first;
    int len;
    int hold;
    int errs_before;
    first = test_first[t];
    len = test_len[t];
    errs_before = mismatch_cnt;
    @(posedge clk);
    rst <= 1'b1;
    imem_we <= 1'b0;
    hold = 0;
    // program load while the core sits in reset
    for (int k = 0; k < len; k++) begin
      @(posedge clk);
      imem_we <= 1'b1;
      imem_addr <= `RV_IMEM_ADDR_W'(k);
      imem_wdata <= tab_insn[first + k];
      hold++;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    hold++;
    while (hold < RESET_CYCLES) begin
      @(posedge clk);
      hold++;
    end
    @(posedge clk);
    rst <= 1'b0;
    // pipe still holds reset bubbles while it fills
    for (int c = 0; c < FILL_CYCLES; c++) begin
      @(negedge clk);
      compare("trace_status", 32'(trace_status), 32'(rv_pkg::CYCLE_RESET));
      compare("trace_we", 32'(trace_we), 32'h0);
      compare("trace_pc", trace_pc, 32'h0);
      compare("trace_insn", trace_insn, 32'h0);
    end
    for (int k = 0; k < len; k++) begin
      @(negedge clk);
      compare("trace_status", 32'(trace_status), 32'(rv_pkg::CYCLE_NO_STALL));
      compare("trace_pc", trace_pc, 32'(k * `RV_PC_STEP));
      compare("trace_insn", trace_insn, tab_insn[first + k]);
      compare("trace_we", 32'(trace_we), 32'(tab_we[first + k]));
      if (tab_we[first + k]) begin
        compare("trace_rd", 32'(trace_rd), 32'(tab_rd[first + k]));
        compare("trace_rd_data", trace_rd_data, tab_data[first + k]);
      end
    end
    if (mismatch_cnt == errs_before) begin
      $display("test %s: ok, %0d rows", test_name[t], len);
    end else begin
      $display("test %s: %0d mismatches", test_name[t], mismatch_cnt - errs_before);
      failed_tests++;
    end
  endtask

  initial begin
    rst = 1'b1;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    build_tables();
    cycle_limit = (RESET_CYCLES + FILL_CYCLES) * tab_insn.size() * 2;
    limit_ready = 1'b1;
    for (int t = 0; t < test_name.size(); t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             test_name.size(), failed_tests, check_cnt, mismatch_cnt);
    if (failed_tests == 0 && mismatch_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
